/* hw/stcPkg.sv */
`default_nettype none

package stcPkg;

    // ************************************************************************
    // Register bus
    // ************************************************************************
    localparam int AddrWidth = 8;
    localparam int DataWidth = 32;

    localparam logic [1:0] RespOkay = 2'b00;

    // Byte offsets of the top register space
    localparam logic [AddrWidth-1:0] RegVersion      = 8'h00;
    localparam logic [AddrWidth-1:0] RegClocksPerBit = 8'h04;
    localparam logic [AddrWidth-1:0] RegDacSelect    = 8'h08;
    localparam logic [AddrWidth-1:0] RegTestLevel    = 8'h0C;
    localparam logic [AddrWidth-1:0] RegControl      = 8'h10;

    // ************************************************************************
    // Bit timing
    // ************************************************************************
    localparam int CpbWidth = 16;

    localparam logic [CpbWidth-1:0] ClocksPerBitReset = 16'd8;
    localparam logic [CpbWidth-1:0] MinClocksPerBit   = 16'd2;   // Shortest legal bit

    // ************************************************************************
    // Sample and DAC words
    // ************************************************************************
    typedef logic [13:0]        adcCode_t;  // Offset binary from the ADC
    typedef logic signed [17:0] sample_t;
    typedef logic [13:0]        dacCode_t;  // Offset binary to the DAC
    typedef logic [3:0]         dacSel_t;

    localparam dacSel_t DacSrcAdc  = 4'd0;
    localparam dacSel_t DacSrcTest = 4'd1;
    localparam dacSel_t DacSrcBits = 4'd2;

    // Square wave levels for the bit monitor
    localparam sample_t SampleMax = 18'sh1FFFF;
    localparam sample_t SampleMin = 18'sh20000;

endpackage

`default_nettype wire

/* hw/axiLiteSlave.sv */
`timescale 1ns/1ps
`default_nettype none

module axiLiteSlave (
    input  wire                              clk,
    input  wire                              rst,

    // Write address and data channels
    input  wire                              awvalid,
    output logic                             awready,
    input  wire  [stcPkg::AddrWidth-1:0]     awaddr,
    input  wire                              wvalid,
    output logic                             wready,
    input  wire  [stcPkg::DataWidth-1:0]     wdata,
    input  wire  [stcPkg::DataWidth/8-1:0]   wstrb,

    // Write response
    output logic                             bvalid,
    input  wire                              bready,
    output logic [1:0]                       bresp,

    // Read address and data channels
    input  wire                              arvalid,
    output logic                             arready,
    input  wire  [stcPkg::AddrWidth-1:0]     araddr,
    output logic                             rvalid,
    input  wire                              rready,
    output logic [stcPkg::DataWidth-1:0]     rdata,
    output logic [1:0]                       rresp,

    // Register bank side
    output logic                             regWrite,
    output logic                             regRead,
    output logic [stcPkg::AddrWidth-1:0]     regAddr,
    output logic [stcPkg::DataWidth-1:0]     regWdata,
    output logic [stcPkg::DataWidth/8-1:0]   regWstrb,
    input  wire  [stcPkg::DataWidth-1:0]     regRdata
);

    typedef enum logic [1:0] {
        idle,
        writeResp,
        readResp
    } state_t;

    state_t state;
    logic   writeReq;
    logic   writeAccept;
    logic   readAccept;

    // ************************************************************************
    // Request arbitration
    // ************************************************************************
    assign writeReq    = awvalid && wvalid;     // Both halves of a write present
    assign writeAccept = (state == idle) && writeReq;
    assign readAccept  = (state == idle) && arvalid && !writeReq;   // Write wins

    assign awready = writeAccept;
    assign wready  = writeAccept;
    assign arready = readAccept;

    // Single cycle strobes into the register bank
    assign regWrite = writeAccept;
    assign regRead  = readAccept;
    assign regAddr  = writeAccept ? awaddr : araddr;
    assign regWdata = wdata;
    assign regWstrb = wstrb;

    // ************************************************************************
    // Transaction FSM
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end
        else begin
            case (state)
                idle: begin
                    if (writeAccept) begin
                        state <= writeResp;
                    end
                    else if (readAccept) begin
                        state <= readResp;
                    end
                end
                writeResp: begin
                    if (bready) begin
                        state <= idle;
                    end
                end
                readResp: begin
                    if (rready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Responses held until the master takes them
    assign bvalid = (state == writeResp);
    assign rvalid = (state == readResp);
    assign bresp  = stcPkg::RespOkay;
    assign rresp  = stcPkg::RespOkay;
    assign rdata  = regRdata;           // Captured by the bank on regRead

    // Read data must not move while the master stalls
    rdataHeld: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata)
    );

endmodule

`default_nettype wire

/* hw/stcRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module stcRegs #(
    parameter int VersionNumber = 643
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              regWrite,
    input  wire                              regRead,
    input  wire  [stcPkg::AddrWidth-1:0]     regAddr,
    input  wire  [stcPkg::DataWidth-1:0]     regWdata,
    input  wire  [stcPkg::DataWidth/8-1:0]   regWstrb,
    output logic [stcPkg::DataWidth-1:0]     regRdata,
    output logic [stcPkg::CpbWidth-1:0]      clocksPerBit,
    output logic                             spectrumInvert,
    output stcPkg::dacSel_t                  dac0Select,
    output stcPkg::dacSel_t                  dac1Select,
    output stcPkg::sample_t                  testLevel
);

    localparam int DW = stcPkg::DataWidth;

    logic [DW-1:0] curWord;
    logic [DW-1:0] mergedWord;

    // Replace only the enabled bytes of a word
    function automatic logic [DW-1:0] byteMerge(
        input logic [DW-1:0]   oldWord,
        input logic [DW-1:0]   newWord,
        input logic [DW/8-1:0] strb
    );
        logic [DW-1:0] merged;
        merged = oldWord;
        for (int i = 0; i < DW/8; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // ************************************************************************
    // Current register contents by offset
    // ************************************************************************
    always_comb begin
        case (regAddr)
            stcPkg::RegVersion:      curWord = {16'b0, 16'(VersionNumber)};
            stcPkg::RegClocksPerBit: curWord = {{(DW-stcPkg::CpbWidth){1'b0}}, clocksPerBit};
            stcPkg::RegDacSelect:    curWord = {24'b0, dac1Select, dac0Select};
            stcPkg::RegTestLevel:    curWord = {14'b0, testLevel};
            stcPkg::RegControl:      curWord = {31'b0, spectrumInvert};
            default:                 curWord = '0;      // Unmapped
        endcase
    end

    assign mergedWord = byteMerge(curWord, regWdata, regWstrb);

    // ************************************************************************
    // Writable registers
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            clocksPerBit   <= stcPkg::ClocksPerBitReset;
            dac0Select     <= stcPkg::DacSrcAdc;
            dac1Select     <= stcPkg::DacSrcAdc;
            testLevel      <= '0;
            spectrumInvert <= 1'b0;
        end
        else if (regWrite) begin
            case (regAddr)
                stcPkg::RegClocksPerBit: begin
                    clocksPerBit <= mergedWord[stcPkg::CpbWidth-1:0];
                end
                stcPkg::RegDacSelect: begin
                    dac0Select <= mergedWord[3:0];
                    dac1Select <= mergedWord[7:4];
                end
                stcPkg::RegTestLevel: begin
                    testLevel <= mergedWord[17:0];
                end
                stcPkg::RegControl: begin
                    spectrumInvert <= mergedWord[0];
                end
                default: begin
                    // Version and unmapped offsets ignore writes
                end
            endcase
        end
    end

    // Read data captured with the read strobe
    always_ff @(posedge clk) begin
        if (regRead) begin
            regRdata <= curWord;
        end
    end

endmodule

`default_nettype wire

/* hw/bitTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module bitTimer (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [stcPkg::CpbWidth-1:0]      clocksPerBit,
    output logic                             bitStrobe,
    output logic                             halfStrobe
);

    logic [stcPkg::CpbWidth-1:0] period;
    logic [stcPkg::CpbWidth-1:0] halfPeriod;
    logic [stcPkg::CpbWidth-1:0] count;

    // Clamp short periods
    assign period = (clocksPerBit < stcPkg::MinClocksPerBit) ?
                    stcPkg::MinClocksPerBit : clocksPerBit;
    assign halfPeriod = period >> 1;    // Rounded down

    always_ff @(posedge clk) begin
        if (rst) begin
            count      <= '0;
            bitStrobe  <= 1'b0;
            halfStrobe <= 1'b0;
        end
        else begin
            // Also catches a count left above a newly shortened period
            if (count >= period - 1'b1) begin
                count <= '0;
            end
            else begin
                count <= count + 1'b1;
            end
            bitStrobe  <= (count >= period - 1'b1);
            halfStrobe <= (count == halfPeriod - 1'b1);
        end
    end

    countInRange: assert property (
        @(posedge clk) disable iff (rst)
        $stable(period) |-> count < period
    );

endmodule

`default_nettype wire

/* hw/adcSlicer.sv */
`timescale 1ns/1ps
`default_nettype none

module adcSlicer (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  stcPkg::adcCode_t           adc,
    input  wire                              bitStrobe,
    input  wire                              halfStrobe,
    input  wire                              spectrumInvert,
    output stcPkg::sample_t                  sample,
    output logic                             bitOut,
    output logic                             chClk,
    output logic                             chData
);

    stcPkg::adcCode_t adcReg;

    // ************************************************************************
    // ADC reclock and conversion to signed
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            adcReg <= '0;
            sample <= '0;
        end
        else begin
            adcReg <= adc;                                      // Pin register
            sample <= {~adcReg[13], adcReg[12:0], 4'b0};        // Offset binary to 2s comp
        end
    end

    // ************************************************************************
    // Hard decision slicer and output clock
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            bitOut <= 1'b0;
            chClk  <= 1'b0;
        end
        else begin
            if (bitStrobe) begin
                bitOut <= ~sample[17] ^ spectrumInvert;  // One for zero and above
                chClk  <= 1'b1;
            end
            else if (halfStrobe) begin
                chClk <= 1'b0;      // Falling edge mid bit
            end
        end
    end

    // Data changes with the rising clock edge
    assign chData = bitOut;

endmodule

`default_nettype wire

/* hw/dacChannel.sv */
`timescale 1ns/1ps
`default_nettype none

module dacChannel (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  stcPkg::dacSel_t            dacSelect,
    input  wire  stcPkg::sample_t            sample,
    input  wire  stcPkg::sample_t            testLevel,
    input  wire                              bitOut,
    output stcPkg::dacCode_t                 dac
);

    stcPkg::sample_t srcReg;

    // Source select
    always_ff @(posedge clk) begin
        if (rst) begin
            srcReg <= '0;
        end
        else begin
            case (dacSelect)
                stcPkg::DacSrcAdc:  srcReg <= sample;
                stcPkg::DacSrcTest: srcReg <= testLevel;
                stcPkg::DacSrcBits: srcReg <= bitOut ? stcPkg::SampleMax : stcPkg::SampleMin;
                default:            srcReg <= '0;
            endcase
        end
    end

    // Top 14 bits, back to offset binary
    always_ff @(posedge clk) begin
        if (rst) begin
            dac <= '0;
        end
        else begin
            dac <= {~srcReg[17], srcReg[16:4]};
        end
    end

    dacKnown: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(dac)
    );

endmodule

`default_nettype wire

/* hw/stcDemodTop.sv */
`timescale 1ns/1ps
`default_nettype none

module stcDemodTop #(
    parameter int VersionNumber = 643
) (
    input  wire                              clk,
    input  wire                              rst,

    // AXI4-Lite slave
    input  wire                              awvalid,
    output logic                             awready,
    input  wire  [stcPkg::AddrWidth-1:0]     awaddr,
    input  wire                              wvalid,
    output logic                             wready,
    input  wire  [stcPkg::DataWidth-1:0]     wdata,
    input  wire  [stcPkg::DataWidth/8-1:0]   wstrb,
    output logic                             bvalid,
    input  wire                              bready,
    output logic [1:0]                       bresp,
    input  wire                              arvalid,
    output logic                             arready,
    input  wire  [stcPkg::AddrWidth-1:0]     araddr,
    output logic                             rvalid,
    input  wire                              rready,
    output logic [stcPkg::DataWidth-1:0]     rdata,
    output logic [1:0]                       rresp,

    // Sample path
    input  wire  stcPkg::adcCode_t           adc,
    output stcPkg::dacCode_t                 dac0,
    output stcPkg::dacCode_t                 dac1,
    output logic                             chClk,
    output logic                             chData
);

    logic                            regWrite;
    logic                            regRead;
    logic [stcPkg::AddrWidth-1:0]    regAddr;
    logic [stcPkg::DataWidth-1:0]    regWdata;
    logic [stcPkg::DataWidth/8-1:0]  regWstrb;
    logic [stcPkg::DataWidth-1:0]    regRdata;
    logic [stcPkg::CpbWidth-1:0]     clocksPerBit;
    logic                            spectrumInvert;
    stcPkg::dacSel_t                 dac0Select;
    stcPkg::dacSel_t                 dac1Select;
    stcPkg::sample_t                 testLevel;
    stcPkg::sample_t                 sample;
    logic                            bitStrobe;
    logic                            halfStrobe;
    logic                            bitOut;

    // ************************************************************************
    // Register access
    // ************************************************************************
    axiLiteSlave bus (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .regWrite(regWrite), .regRead(regRead), .regAddr(regAddr),
        .regWdata(regWdata), .regWstrb(regWstrb), .regRdata(regRdata)
    );

    stcRegs #(.VersionNumber(VersionNumber)) regs (
        .clk(clk), .rst(rst),
        .regWrite(regWrite), .regRead(regRead), .regAddr(regAddr),
        .regWdata(regWdata), .regWstrb(regWstrb), .regRdata(regRdata),
        .clocksPerBit(clocksPerBit), .spectrumInvert(spectrumInvert),
        .dac0Select(dac0Select), .dac1Select(dac1Select), .testLevel(testLevel)
    );

    // ************************************************************************
    // Bit timing, slicer and DAC monitors
    // ************************************************************************
    bitTimer timer (
        .clk(clk), .rst(rst), .clocksPerBit(clocksPerBit),
        .bitStrobe(bitStrobe), .halfStrobe(halfStrobe)
    );

    adcSlicer slicer (
        .clk(clk), .rst(rst), .adc(adc),
        .bitStrobe(bitStrobe), .halfStrobe(halfStrobe), .spectrumInvert(spectrumInvert),
        .sample(sample), .bitOut(bitOut), .chClk(chClk), .chData(chData)
    );

    dacChannel dac0Chan (
        .clk(clk), .rst(rst), .dacSelect(dac0Select),
        .sample(sample), .testLevel(testLevel), .bitOut(bitOut), .dac(dac0)
    );

    dacChannel dac1Chan (
        .clk(clk), .rst(rst), .dacSelect(dac1Select),
        .sample(sample), .testLevel(testLevel), .bitOut(bitOut), .dac(dac1)
    );

endmodule

`default_nettype wire

/* verif/tbClockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int Period      = 4,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // Released on a falling edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/stcDemodTb.sv */
`timescale 1ns/1ps
`default_nettype none

module stcDemodTb;

    localparam int OpWrite  = 0;
    localparam int OpRead   = 1;
    localparam int OpStall  = 2;    // Read with rready held low
    localparam int OpAdc    = 3;
    localparam int OpRandom = 4;
    localparam int OpLevel  = 5;
    localparam int OpBits   = 6;

    logic clk;
    logic rst;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [stcPkg::AddrWidth-1:0] awaddr, araddr;
    logic [stcPkg::DataWidth-1:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    stcPkg::adcCode_t adc;
    stcPkg::dacCode_t dac0, dac1;
    logic chClk, chData;

    string       stepName[$];
    int          stepKind[$];
    logic [7:0]  stepAddr[$];
    logic [31:0] stepData[$];
    logic [3:0]  stepStrb[$];
    logic [31:0] stepExp[$];
    logic [13:0] adcStream[$];
    logic [13:0] lastAdc;
    logic [31:0] got;
    logic        tableReady = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          randomTotal = 0;
    int          rnd;
    integer      seed;

    tbClockGen #(.Period(4), .ResetCycles(4)) clkGen (.clk(clk), .rst(rst));

    stcDemodTop #(.VersionNumber(643)) UUT (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .adc(adc), .dac0(dac0), .dac1(dac1), .chClk(chClk), .chData(chData)
    );

    // Midscale code and above is a sample of zero or more
    function automatic logic bitFor(input logic [13:0] code, input logic inv);
        return (code >= 14'h2000) ^ inv;
    endfunction

    task automatic addStep(input string name, input int kind, input logic [7:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [31:0] expVal);
        stepName.push_back(name);
        stepKind.push_back(kind);
        stepAddr.push_back(addr);
        stepData.push_back(data);
        stepStrb.push_back(strb);
        stepExp.push_back(expVal);
        if (kind == OpRandom) begin
            randomTotal += data;
        end
    endtask

    task automatic compareWord(input string name, input logic [31:0] expVal,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expVal) begin
            errors++;
            $display("** Error: %s expected %h actual %h at %0t", name, expVal, actual, $time);
        end
    endtask

    // ************************************************************************
    // Stimulus table
    // ************************************************************************
    task automatic buildTable();
        // Reset values
        addStep("version reset", OpRead, stcPkg::RegVersion, 0, 0, 643);
        addStep("clocksPerBit reset", OpRead, stcPkg::RegClocksPerBit, 0, 0, 8);
        addStep("dacSelect reset", OpRead, stcPkg::RegDacSelect, 0, 0, 0);
        addStep("testLevel reset", OpRead, stcPkg::RegTestLevel, 0, 0, 0);
        addStep("control reset", OpRead, stcPkg::RegControl, 0, 0, 0);
        addStep("unmapped 0x14", OpRead, 8'h14, 0, 0, 0);
        addStep("unmapped 0xFC", OpRead, 8'hFC, 0, 0, 0);
        // Full and byte enabled writes
        addStep("cpb write", OpWrite, stcPkg::RegClocksPerBit, 32'h0000_000A, 4'hF, 0);
        addStep("cpb readback", OpRead, stcPkg::RegClocksPerBit, 0, 0, 32'hA);
        addStep("level byte0", OpWrite, stcPkg::RegTestLevel, 32'h1234_5678, 4'b0001, 0);
        addStep("level byte0 readback", OpRead, stcPkg::RegTestLevel, 0, 0, 32'h78);
        addStep("level byte2", OpWrite, stcPkg::RegTestLevel, 32'hABCD_EF00, 4'b0100, 0);
        addStep("level byte2 readback", OpRead, stcPkg::RegTestLevel, 0, 0, 32'h1_0078);
        addStep("control byte1", OpWrite, stcPkg::RegControl, 32'hFFFF_FFFF, 4'b0010, 0);
        addStep("control byte1 readback", OpRead, stcPkg::RegControl, 0, 0, 0);
        addStep("control set", OpWrite, stcPkg::RegControl, 32'h1, 4'hF, 0);
        addStep("control readback", OpRead, stcPkg::RegControl, 0, 0, 1);
        addStep("control clear", OpWrite, stcPkg::RegControl, 32'h0, 4'hF, 0);
        addStep("dacSelect write", OpWrite, stcPkg::RegDacSelect, 32'hFFFF_FFF1, 4'b0001, 0);
        addStep("dacSelect readback", OpRead, stcPkg::RegDacSelect, 0, 0, 32'hF1);
        addStep("dacSelect clear", OpWrite, stcPkg::RegDacSelect, 32'h0, 4'hF, 0);
        addStep("version write", OpWrite, stcPkg::RegVersion, 32'hFFFF_FFFF, 4'hF, 0);
        addStep("version readback", OpRead, stcPkg::RegVersion, 0, 0, 643);
        addStep("unmapped write", OpWrite, 8'h14, 32'hFFFF_FFFF, 4'hF, 0);
        addStep("unmapped readback", OpRead, 8'h14, 0, 0, 0);
        addStep("stalled read", OpStall, stcPkg::RegClocksPerBit, 5, 0, 32'hA);
        // ADC to DAC loopback
        addStep("adc 0x0000", OpAdc, 0, 14'h0000, 0, 0);
        addStep("adc 0x3FFF", OpAdc, 0, 14'h3FFF, 0, 0);
        addStep("adc 0x2000", OpAdc, 0, 14'h2000, 0, 0);
        addStep("adc 0x1FFF", OpAdc, 0, 14'h1FFF, 0, 0);
        addStep("adc 0x0001", OpAdc, 0, 14'h0001, 0, 0);
        addStep("adc 0x2AAA", OpAdc, 0, 14'h2AAA, 0, 0);
        addStep("adc random", OpRandom, 0, 64, 0, 0);
        // Test level on dac1, expected words worked out by hand
        addStep("level positive", OpWrite, stcPkg::RegTestLevel, 32'h0001_ABCD, 4'hF, 0);
        addStep("dac1 to test", OpWrite, stcPkg::RegDacSelect, 32'h10, 4'hF, 0);
        addStep("dac1 positive level", OpLevel, 0, 0, 0, 14'h3ABC);
        addStep("level negative", OpWrite, stcPkg::RegTestLevel, 32'h0002_0010, 4'hF, 0);
        addStep("dac1 negative level", OpLevel, 0, 0, 0, 14'h0001);
        addStep("dacs to adc", OpWrite, stcPkg::RegDacSelect, 32'h0, 4'hF, 0);
        // Sliced bits, data column is clocksPerBit
        addStep("adc positive", OpAdc, 0, 14'h3000, 0, 0);
        addStep("dac0 to bits", OpWrite, stcPkg::RegDacSelect, 32'h2, 4'hF, 0);
        addStep("bits cpb4", OpBits, 0, 4, 0, bitFor(14'h3000, 1'b0));
        addStep("invert on", OpWrite, stcPkg::RegControl, 32'h1, 4'hF, 0);
        addStep("bits cpb4 inverted", OpBits, 0, 4, 0, bitFor(14'h3000, 1'b1));
        addStep("dac0 to adc", OpWrite, stcPkg::RegDacSelect, 32'h0, 4'hF, 0);
        addStep("adc negative", OpAdc, 0, 14'h0800, 0, 0);
        addStep("dac0 back to bits", OpWrite, stcPkg::RegDacSelect, 32'h2, 4'hF, 0);
        addStep("bits cpb3 inverted", OpBits, 0, 3, 0, bitFor(14'h0800, 1'b1));
        addStep("invert off", OpWrite, stcPkg::RegControl, 32'h0, 4'hF, 0);
        addStep("bits cpb7", OpBits, 0, 7, 0, bitFor(14'h0800, 1'b0));
        addStep("bits cpb1 clamped", OpBits, 0, 1, 0, bitFor(14'h0800, 1'b0));
        addStep("bits cpb0 clamped", OpBits, 0, 0, 0, bitFor(14'h0800, 1'b0));
    endtask

    // ************************************************************************
    // Bus tasks, all start and end on a falling edge
    // ************************************************************************
    task automatic busWrite(input string name, input logic [7:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
        int waitCycles;
        int awPulses;
        int wPulses;
        waitCycles = 0;
        awPulses   = 0;
        wPulses    = 0;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        do begin
            @(posedge clk);     // Ready lines seen as they were before the edge
            if (awready) begin
                awPulses++;
            end
            if (wready) begin
                wPulses++;
            end
            @(negedge clk);
            waitCycles++;
        end while (!bvalid && waitCycles < 20);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        checks++;
        if (!bvalid) begin
            errors++;
            $display("%s: write got no response from the DUT", name);
        end
        else begin
            compareWord({name, " awready pulses"}, 1, awPulses);
            compareWord({name, " wready pulses"}, 1, wPulses);
            compareWord({name, " bresp"}, 0, bresp);
        end
    endtask

    task automatic busRead(input string name, input logic [7:0] addr, input int stall,
                           output logic [31:0] data);
        int waitCycles;
        int arPulses;
        waitCycles = 0;
        arPulses   = 0;
        arvalid = 1'b1;
        araddr  = addr;
        do begin
            @(posedge clk);
            if (arready) begin
                arPulses++;
            end
            @(negedge clk);
            waitCycles++;
        end while (!rvalid && waitCycles < 20);
        arvalid = 1'b0;
        data    = rdata;
        checks++;
        if (!rvalid) begin
            errors++;
            $display("%s: read got no response from the DUT", name);
        end
        else begin
            compareWord({name, " arready pulses"}, 1, arPulses);
            repeat (stall) begin
                @(negedge clk);
                checks++;
                if (!rvalid) begin
                    errors++;
                    $display("%s: rvalid dropped while rready was low", name);
                end
                compareWord({name, " held rdata"}, data, rdata);
            end
            compareWord({name, " rresp"}, 0, rresp);
            rready = 1'b1;
            @(negedge clk);
            rready = 1'b0;
        end
    endtask

    // Code k goes in at edge k and must show on both DACs at edge k + 4
    task automatic runStream(input string name);
        logic [13:0] expCode;
        int n;
        n = adcStream.size();
        repeat (4) @(negedge clk);      // Select changes settle
        for (int k = 0; k < n + 4; k++) begin
            expCode = (k >= 4) ? adcStream[k-4] : lastAdc;
            compareWord({name, " dac0"}, expCode, dac0);
            compareWord({name, " dac1"}, expCode, dac1);
            if (k < n) begin
                adc = adcStream[k];
            end
            @(negedge clk);
        end
        lastAdc = adcStream[n-1];
    endtask

    task automatic bitCheck(input string name, input logic [31:0] cpb, input logic expBit);
        int period;
        int cycle;
        int lastRise;
        int rises;
        logic prevClk;
        busWrite(name, stcPkg::RegClocksPerBit, cpb, 4'hF);
        period = (cpb < stcPkg::MinClocksPerBit) ? stcPkg::MinClocksPerBit : cpb;
        repeat (2 * period + 8) @(negedge clk);
        prevClk  = chClk;
        cycle    = 0;
        lastRise = -1;
        rises    = 0;
        while (rises < 4 && cycle < 4 * period + 8) begin
            @(negedge clk);
            cycle++;
            if (chClk && !prevClk) begin
                if (lastRise >= 0) begin
                    compareWord({name, " period"}, period, cycle - lastRise);
                end
                compareWord({name, " chData"}, expBit, chData);
                lastRise = cycle;
                rises++;
            end
            prevClk = chClk;
        end
        checks++;
        if (rises < 4) begin
            errors++;
            $display("%s: chClk stopped toggling", name);
        end
        compareWord({name, " dac0"}, expBit ? 14'h3FFF : 14'h0000, dac0);
    endtask

    // ************************************************************************
    // Main sequence and watchdog
    // ************************************************************************
    initial begin
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b1;     // Write responses taken at once
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        adc     = 14'h2000; // Midscale
        lastAdc = 14'h2000;
        seed    = 32'h2ce23aa3;
        buildTable();
        tableReady = 1'b1;
        @(negedge clk);
        while (rst) @(negedge clk);
        repeat (4) @(negedge clk);
        for (int i = 0; i < stepKind.size(); i++) begin
            case (stepKind[i])
                OpWrite: busWrite(stepName[i], stepAddr[i], stepData[i], stepStrb[i]);
                OpRead: begin
                    busRead(stepName[i], stepAddr[i], 0, got);
                    compareWord(stepName[i], stepExp[i], got);
                end
                OpStall: begin
                    busRead(stepName[i], stepAddr[i], stepData[i], got);
                    compareWord(stepName[i], stepExp[i], got);
                end
                OpAdc: begin
                    adcStream.delete();
                    adcStream.push_back(stepData[i][13:0]);
                    runStream(stepName[i]);
                end
                OpRandom: begin
                    adcStream.delete();
                    for (int k = 0; k < stepData[i]; k++) begin
                        rnd = $random(seed);
                        adcStream.push_back(rnd[13:0]);
                    end
                    runStream(stepName[i]);
                end
                OpLevel: begin
                    repeat (4) @(negedge clk);
                    compareWord(stepName[i], stepExp[i], dac1);
                end
                OpBits: bitCheck(stepName[i], stepData[i], stepExp[i][0]);
                default: begin
                    errors++;
                    $display("%s: unknown step kind %0d", stepName[i], stepKind[i]);
                end
            endcase
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        int budget;
        wait (tableReady);
        budget = stepKind.size() * 40 + randomTotal + 200;     // Cycles
        repeat (budget) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", budget);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/stcPkg.sv
hw/axiLiteSlave.sv
hw/stcRegs.sv
hw/bitTimer.sv
hw/adcSlicer.sv
hw/dacChannel.sv
hw/stcDemodTop.sv
verif/tbClockGen.sv
verif/stcDemodTb.sv

/* Bender.yml */
package:
  name: stc_demod

sources:
  # RTL in compile order
  - hw/stcPkg.sv
  - hw/axiLiteSlave.sv
  - hw/stcRegs.sv
  - hw/bitTimer.sv
  - hw/adcSlicer.sv
  - hw/dacChannel.sv
  - hw/stcDemodTop.sv

  # Testbench
  - target: test
    files:
      - verif/tbClockGen.sv
      - verif/stcDemodTb.sv
